//--- mini_soc_trace.txt
# test op addr wdata exp_rdata exp_err exp_irq
# op is R or W, all numbers in hex, one access per line
l2_wr_0 W 00000000 11223344 00000000 0 0
l2_wr_top W 000003fc deadbeef 00000000 0 0
l2_rd_0 R 00000000 00000000 11223344 0 0
l2_rd_top R 000003fc 00000000 deadbeef 0 0
unmap_rd R 00020000 00000000 00000000 1 0
unmap_wr W 00020000 12345678 00000000 1 0
unmap_l2_end R 00000400 00000000 00000000 1 0
mb_stat_reset R 00010004 00000000 00000200 0 0
mb_rd_empty R 00010000 00000000 00000000 1 0
mb_push_1 W 00010000 000000a1 00000000 0 0
mb_push_2 W 00010000 000000a2 00000000 0 0
mb_push_3 W 00010000 000000a3 00000000 0 0
mb_stat_three R 00010004 00000000 00000003 0 0
mb_thresh_set W 00010008 00000003 00000000 0 0
mb_thresh_rd R 00010008 00000000 00000003 0 0
mb_en_set W 0001000c 00000001 00000000 0 1
mb_en_rd R 0001000c 00000000 00000001 0 1
mb_pop_1 R 00010000 00000000 000000a1 0 0
mb_push_4 W 00010000 000000a4 00000000 0 1
mb_push_5 W 00010000 000000a5 00000000 0 1
mb_push_6 W 00010000 000000a6 00000000 0 1
mb_push_7 W 00010000 000000a7 00000000 0 1
mb_push_8 W 00010000 000000a8 00000000 0 1
mb_push_9 W 00010000 000000a9 00000000 0 1
mb_stat_full R 00010004 00000000 00000108 0 1
mb_push_over W 00010000 000000aa 00000000 1 1
mb_stat_over R 00010004 00000000 00000108 0 1
mb_stat_wr W 00010004 ffffffff 00000000 0 1
mb_pop_2 R 00010000 00000000 000000a2 0 1
mb_pop_3 R 00010000 00000000 000000a3 0 1
mb_en_clear W 0001000c 00000000 00000000 0 0

//--- mini_soc.f
soc_pkg.sv
soc_bus_decode.sv
l2_mem.sv
mbox_fifo.sv
mbox_regs.sv
mini_soc.sv
tb_mini_soc.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mini_soc
FILELIST  := mini_soc.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_mini_soc.sv
// ####################################################################
// testbench for mini_soc, stimulus and expectations from the trace
// run from the project root so mini_soc_trace.txt is found
// one access every two clocks, response checked one cycle later
// irq checked one further cycle later, once the count has settled
// ends with an LCG fill and readback over the whole L2
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

module tb_mini_soc import soc_pkg::*; ();

  localparam int CLK_HALF = 20;

  typedef struct packed {
    logic  we;
    addr_t addr;
    data_t wdata;
    data_t rdata;
    logic  err;
    logic  irq;
  } trace_entry_t;

  logic     clk_i;
  logic     rst_n_i;
  logic     req_valid_i;
  soc_req_t req_i;
  logic     rsp_valid_o;
  soc_rsp_t rsp_o;
  logic     mbox_irq_o;

  string        names [$];
  trace_entry_t trace_q [$];
  data_t        l2_model [L2_WORDS];
  logic [31:0]  lcg_state;
  int           pass_cnt = 0;
  int           fail_cnt = 0;
  int           cycle_cnt = 0;
  int           cycle_limit = 0;

  mini_soc mini_soc_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .mbox_irq_o  (mbox_irq_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #CLK_HALF clk_i = ~clk_i;
    end
  end

  // guard armed once the trace length is known
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("ERROR: run did not finish within %0d cycles", cycle_limit);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input string test, input string what, input data_t exp_val,
                             input data_t act_val, inout bit ok);
    if (exp_val !== act_val) begin
      $display("FAILED %s: %s expected %h actual %h", test, what, exp_val, act_val);
      ok = 1'b0;
    end
  endtask

  task automatic finish_test(input string test, input bit ok);
    if (ok) begin
      pass_cnt++;
      $display("[pass] %s", test);
    end else begin
      fail_cnt++;
      $display("[fail] %s", test);
    end
  endtask

  task automatic load_trace(output bit ok);
    int           fd;
    int           code;
    int           c;
    string        name;
    string        op;
    addr_t        t_addr;
    data_t        t_wdata;
    data_t        t_rdata;
    logic         t_err;
    logic         t_irq;
    trace_entry_t ent;
    ok = 1'b1;
    fd = $fopen("mini_soc_trace.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open mini_soc_trace.txt");
      ok = 1'b0;
    end else begin
      while (ok) begin
        code = $fscanf(fd, "%s", name);
        if (code != 1) begin
          break;
        end
        if (name.substr(0, 0) == "#") begin
          // comment, skip to end of line
          c = $fgetc(fd);
          while (c != 10 && c != -1) begin
            c = $fgetc(fd);
          end
        end else begin
          code = $fscanf(fd, "%s %h %h %h %h %h", op, t_addr, t_wdata, t_rdata, t_err, t_irq);
          if (code != 6) begin
            $display("ERROR: trace line for %s is malformed", name);
            ok = 1'b0;
          end else begin
            ent.we    = (op == "W");
            ent.addr  = t_addr;
            ent.wdata = t_wdata;
            ent.rdata = t_rdata;
            ent.err   = t_err;
            ent.irq   = t_irq;
            names.push_back(name);
            trace_q.push_back(ent);
          end
        end
      end
      $fclose(fd);
    end
    if (ok && trace_q.size() == 0) begin
      $display("ERROR: trace holds no accesses");
      ok = 1'b0;
    end
  endtask

  task automatic drive_access(input logic we, input addr_t addr, input data_t wdata);
    @(posedge clk_i);
    req_valid_i   <= 1'b1;
    req_i.addr    <= addr;
    req_i.we      <= we;
    req_i.wdata   <= wdata;
  endtask

  // drop the strobe, then sample the answer mid-cycle
  task automatic collect_response(input string test, output soc_rsp_t rsp, inout bit ok);
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    @(negedge clk_i);
    rsp = rsp_o;
    if (rsp_valid_o !== 1'b1) begin
      $display("ERROR %s: no response in the cycle after the request", test);
      ok = 1'b0;
    end
  endtask

  task automatic check_irq(input int idx, input bit ok);
    check_value(names[idx], "irq", data_t'(trace_q[idx].irq), data_t'(mbox_irq_o), ok);
    finish_test(names[idx], ok);
  endtask

  task automatic run_trace();
    soc_rsp_t rsp;
    bit       ok;
    bit       prev_ok;
    prev_ok = 1'b1;
    for (int i = 0; i < trace_q.size(); i++) begin
      drive_access(trace_q[i].we, trace_q[i].addr, trace_q[i].wdata);
      // irq of the previous access has settled by now
      @(negedge clk_i);
      if (i > 0) begin
        check_irq(i - 1, prev_ok);
      end
      ok = 1'b1;
      collect_response(names[i], rsp, ok);
      check_value(names[i], "rdata", trace_q[i].rdata, rsp.rdata, ok);
      check_value(names[i], "err", data_t'(trace_q[i].err), data_t'(rsp.err), ok);
      prev_ok = ok;
    end
    @(posedge clk_i);
    @(negedge clk_i);
    check_irq(trace_q.size() - 1, prev_ok);
  endtask

  task automatic run_l2_sweep();
    soc_rsp_t rsp;
    bit       ok;
    addr_t    addr;
    ok = 1'b1;
    lcg_state = 32'hc2a1_a221;
    for (int i = 0; i < int'(L2_WORDS); i++) begin
      addr = L2_BASE + addr_t'(i * 4);
      l2_model[i] = lcg_next() ^ addr;
      drive_access(1'b1, addr, l2_model[i]);
      collect_response("l2_lcg_sweep", rsp, ok);
      check_value("l2_lcg_sweep", "write rdata", '0, rsp.rdata, ok);
      check_value("l2_lcg_sweep", "write err", '0, data_t'(rsp.err), ok);
    end
    for (int i = 0; i < int'(L2_WORDS); i++) begin
      addr = L2_BASE + addr_t'(i * 4);
      drive_access(1'b0, addr, '0);
      collect_response("l2_lcg_sweep", rsp, ok);
      check_value("l2_lcg_sweep", "read rdata", l2_model[i], rsp.rdata, ok);
      check_value("l2_lcg_sweep", "read err", '0, data_t'(rsp.err), ok);
    end
    finish_test("l2_lcg_sweep", ok);
  endtask

  initial begin
    bit loaded;
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    load_trace(loaded);
    if (!loaded) begin
      $display("TESTS FAILED");
      $finish;
    end else begin
      cycle_limit = 4 * trace_q.size() + 2 * int'(L2_WORDS) * 2 + 50;
      repeat (2) @(posedge clk_i);
      rst_n_i <= 1'b1;
      run_trace();
      run_l2_sweep();
      $display("summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
        $display("TESTS PASSED");
      end else begin
        $display("TESTS FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- mini_soc.sv
// ####################################################################
// mini SoC top: one request port, L2 memory and a host mailbox
// one access per strobe, response exactly one cycle later
// L2 at 0x0000_0000 (1 KiB), mailbox at 0x0001_0000 (16 B)
// mbox_irq_o is a level driven from the mailbox count
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

module mini_soc import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     req_valid_i,
  input  soc_req_t req_i,
  output logic     rsp_valid_o,
  output soc_rsp_t rsp_o,
  output logic     mbox_irq_o
);

  logic      l2_sel;
  l2_acc_t   l2_acc;
  data_t     l2_rdata;
  logic      mbox_sel;
  mbox_acc_t mbox_acc;
  soc_rsp_t  mbox_rsp;

  // register block to FIFO
  logic      push;
  data_t     push_data;
  logic      pop;
  data_t     head;
  mbox_cnt_t count;
  logic      full;
  logic      empty;

  soc_bus_decode i_bus_decode (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .l2_sel_o    (l2_sel),
    .l2_acc_o    (l2_acc),
    .l2_rdata_i  (l2_rdata),
    .mbox_sel_o  (mbox_sel),
    .mbox_acc_o  (mbox_acc),
    .mbox_rsp_i  (mbox_rsp),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

  l2_mem i_l2_mem (
    .clk_i    (clk_i),
    .l2_sel_i (l2_sel),
    .l2_acc_i (l2_acc),
    .rdata_o  (l2_rdata)
  );

  mbox_regs i_mbox_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .sel_i       (mbox_sel),
    .acc_i       (mbox_acc),
    .rsp_o       (mbox_rsp),
    .push_o      (push),
    .push_data_o (push_data),
    .pop_o       (pop),
    .head_i      (head),
    .count_i     (count),
    .full_i      (full),
    .empty_i     (empty),
    .irq_o       (mbox_irq_o)
  );

  mbox_fifo i_mbox_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (pop),
    .head_o      (head),
    .count_o     (count),
    .full_o      (full),
    .empty_o     (empty)
  );

endmodule

`default_nettype wire

//--- mbox_regs.sv
// ####################################################################
// host-side mailbox registers: data, status, threshold, irq enable
// overflow and underflow are refused and answered with err
// response is registered, one cycle after the select
// irq is a level, one cycle behind the FIFO count
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

module mbox_regs import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      sel_i,
  input  mbox_acc_t acc_i,
  output soc_rsp_t  rsp_o,
  output logic      push_o,
  output data_t     push_data_o,
  output logic      pop_o,
  input  data_t     head_i,
  input  mbox_cnt_t count_i,
  input  logic      full_i,
  input  logic      empty_i,
  output logic      irq_o
);

  logic      data_acc;
  data_t     status_word;
  soc_rsp_t  rsp_d;
  soc_rsp_t  rsp_q;
  mbox_cnt_t thresh_q;
  logic      irq_en_q;
  logic      irq_q;

  assign data_acc    = sel_i && (acc_i.reg_sel == MBOX_DATA);
  assign push_o      = data_acc && acc_i.we && !full_i;
  assign pop_o       = data_acc && !acc_i.we && !empty_i;
  assign push_data_o = acc_i.wdata;

  always_comb begin
    status_word                            = '0;
    status_word[$bits(mbox_cnt_t)-1:0]     = count_i;
    status_word[STAT_FULL_BIT]             = full_i;
    status_word[STAT_EMPTY_BIT]            = empty_i;
  end

  // writes always return zero data
  always_comb begin
    rsp_d.rdata = '0;
    rsp_d.err   = 1'b0;
    case (acc_i.reg_sel)
      MBOX_DATA: begin
        rsp_d.err = acc_i.we ? full_i : empty_i;
        if (!acc_i.we && !empty_i) begin
          rsp_d.rdata = head_i;
        end
      end
      MBOX_STATUS: rsp_d.rdata = acc_i.we ? '0 : status_word;
      MBOX_THRESH: rsp_d.rdata = acc_i.we ? '0 : data_t'(thresh_q);
      default:     rsp_d.rdata = acc_i.we ? '0 : data_t'(irq_en_q);
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_o = rsp_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      thresh_q <= mbox_cnt_t'(1);
      irq_en_q <= 1'b0;
      irq_q    <= 1'b0;
    end else begin
      if (sel_i && acc_i.we && (acc_i.reg_sel == MBOX_THRESH)) begin
        thresh_q <= acc_i.wdata[$bits(mbox_cnt_t)-1:0];
      end
      if (sel_i && acc_i.we && (acc_i.reg_sel == MBOX_IRQ_EN)) begin
        irq_en_q <= acc_i.wdata[0];
      end
      // zero threshold keeps the line quiet
      irq_q <= irq_en_q && (thresh_q != '0) && (count_i >= thresh_q);
    end
  end

  assign irq_o = irq_q;

  // status and the push and pop guards rely on flags that agree with the count
  a_flags_match: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (full_i == (count_i == mbox_cnt_t'(MBOX_DEPTH))) && (empty_i == (count_i == '0)));

endmodule

`default_nettype wire

//--- mbox_fifo.sv
// ####################################################################
// mailbox storage, 8-entry circular buffer
// callers must not push while full or pop while empty
// push and pop in one cycle keep the count unchanged
// head_o shows the oldest entry, undefined while empty
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

module mbox_fifo import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      push_i,
  input  data_t     push_data_i,
  input  logic      pop_i,
  output data_t     head_o,
  output mbox_cnt_t count_o,
  output logic      full_o,
  output logic      empty_o
);

  localparam int unsigned PTR_W = $clog2(MBOX_DEPTH);

  data_t            mem [MBOX_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  mbox_cnt_t        count_q;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  // pointers wrap on their own, depth is a power of 2
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign head_o  = mem[rd_ptr_q];
  assign count_o = count_q;
  assign full_o  = (count_q == mbox_cnt_t'(MBOX_DEPTH));
  assign empty_o = (count_q == '0);

  // guarding lives in the register block
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_o);
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty_o);

endmodule

`default_nettype wire

//--- l2_mem.sv
// ####################################################################
// word-addressed L2 memory, one port, 256 words
// read data appears one cycle after the select
// a write returns zero as read data
// contents are undefined after power-up
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

module l2_mem import soc_pkg::*; (
  input  logic    clk_i,
  input  logic    l2_sel_i,
  input  l2_acc_t l2_acc_i,
  output data_t   rdata_o
);

  data_t mem [L2_WORDS];
  data_t rdata_q;

  // write port
  always_ff @(posedge clk_i) begin
    if (l2_sel_i && l2_acc_i.we) begin
      mem[l2_acc_i.idx] <= l2_acc_i.wdata;
    end
  end

  // registered read, zero for writes
  always_ff @(posedge clk_i) begin
    if (l2_sel_i) begin
      if (l2_acc_i.we) begin
        rdata_q <= '0;
      end else begin
        rdata_q <= mem[l2_acc_i.idx];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- soc_bus_decode.sv
// ####################################################################
// single-initiator bus decoder with a fixed one-cycle response
// every strobe is accepted, there is no back-pressure
// targets must answer exactly one cycle after their select
// unmapped addresses answer err with zero read data
// ####################################################################

`timescale 1ns/1ps
`default_nettype none

module soc_bus_decode import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      req_valid_i,
  input  soc_req_t  req_i,
  output logic      l2_sel_o,
  output l2_acc_t   l2_acc_o,
  input  data_t     l2_rdata_i,
  output logic      mbox_sel_o,
  output mbox_acc_t mbox_acc_o,
  input  soc_rsp_t  mbox_rsp_i,
  output logic      rsp_valid_o,
  output soc_rsp_t  rsp_o
);

  addr_t l2_off;
  addr_t mbox_off;
  tgt_e  tgt;
  tgt_e  tgt_q;
  logic  rsp_valid_q;

  // an address below a base wraps to a large offset and misses
  assign l2_off   = req_i.addr - L2_BASE;
  assign mbox_off = req_i.addr - MBOX_BASE;

  always_comb begin
    if (l2_off < L2_SPAN) begin
      tgt = TGT_L2;
    end else if (mbox_off < MBOX_SPAN) begin
      tgt = TGT_MBOX;
    end else begin
      tgt = TGT_NONE;
    end
  end

  assign l2_sel_o       = req_valid_i && (tgt == TGT_L2);
  assign l2_acc_o.idx   = l2_off[2 +: $bits(l2_idx_t)];
  assign l2_acc_o.we    = req_i.we;
  assign l2_acc_o.wdata = req_i.wdata;

  assign mbox_sel_o         = req_valid_i && (tgt == TGT_MBOX);
  assign mbox_acc_o.reg_sel = mbox_reg_e'(mbox_off[3:2]);
  assign mbox_acc_o.we      = req_i.we;
  assign mbox_acc_o.wdata   = req_i.wdata;

  // remember who owes the answer
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
      tgt_q       <= TGT_NONE;
    end else begin
      rsp_valid_q <= req_valid_i;
      tgt_q       <= req_valid_i ? tgt : TGT_NONE;
    end
  end

  assign rsp_valid_o = rsp_valid_q;

  always_comb begin
    case (tgt_q)
      TGT_L2: begin
        rsp_o.rdata = l2_rdata_i;
        rsp_o.err   = 1'b0;
      end
      TGT_MBOX: rsp_o = mbox_rsp_i;
      default: begin
        rsp_o.rdata = '0;
        rsp_o.err   = 1'b1;
      end
    endcase
  end

  // routing needs a known address on every strobe
  a_addr_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i |-> !$isunknown({req_i.addr, req_i.we}));

endmodule

`default_nettype wire

//--- soc_pkg.sv
// ####################################################################
// shared widths, address map and bus types of the mini SoC
// L2 and mailbox windows are fixed here and must not overlap
// addresses are byte addresses, all accesses are full 32-bit words
// the two low address bits are ignored by every target
// ####################################################################

`default_nettype none

package soc_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // L2 memory window, 256 words
  localparam addr_t       L2_BASE  = 32'h0000_0000;
  localparam int unsigned L2_WORDS = 256;
  localparam addr_t       L2_SPAN  = addr_t'(L2_WORDS * 4);

  typedef logic [7:0] l2_idx_t;

  // mailbox window, four word registers
  localparam addr_t       MBOX_BASE  = 32'h0001_0000;
  localparam addr_t       MBOX_SPAN  = 32'd16;
  localparam int unsigned MBOX_DEPTH = 8;

  // status word layout, count sits in the low bits
  localparam int unsigned STAT_FULL_BIT  = 8;
  localparam int unsigned STAT_EMPTY_BIT = 9;

  typedef logic [3:0] mbox_cnt_t;

  // register index is the word offset inside the window
  typedef enum logic [1:0] {
    MBOX_DATA   = 2'd0,
    MBOX_STATUS = 2'd1,
    MBOX_THRESH = 2'd2,
    MBOX_IRQ_EN = 2'd3
  } mbox_reg_e;

  typedef enum logic [1:0] {
    TGT_NONE = 2'd0,
    TGT_L2   = 2'd1,
    TGT_MBOX = 2'd2
  } tgt_e;

  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
  } soc_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } soc_rsp_t;

  typedef struct packed {
    mbox_reg_e reg_sel;
    logic      we;
    data_t     wdata;
  } mbox_acc_t;

  typedef struct packed {
    l2_idx_t idx;
    logic    we;
    data_t   wdata;
  } l2_acc_t;

endpackage

`default_nettype wire
